//--- rtl/pyr_pkg.sv
`default_nettype none

package pyr_pkg;

    localparam int PIX_W      = 8;
    localparam int BEAT_PIX   = 8;
    localparam int BEAT_W     = PIX_W * BEAT_PIX;
    localparam int GRP_PIX    = 4;     // one output group per input beat
    localparam int HSUM_W     = 12;    // up to 16 x 255
    localparam int VSUM_W     = 16;
    localparam logic [VSUM_W-1:0] ROUND = VSUM_W'(128);

    localparam int MAX_WIDTH  = 512;
    localparam int MAX_HEIGHT = 512;
    localparam int WIDTH_W    = 10;
    localparam int HEIGHT_W   = 10;
    localparam int GRP_ADDR_W = 6;     // group index within a row

    // line buffer banks
    localparam int N_LINES    = 5;
    localparam int BANK_W     = 3;
    localparam logic [BANK_W-1:0] TAP_CUR = BANK_W'(5);  // current row, not a bank

    typedef enum logic {
        BORDER_REPLICATE,
        BORDER_REFLECT_101
    } border_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ROW,
        ST_DRAIN,
        ST_DONE
    } ctrl_state_e;

    typedef logic [GRP_PIX-1:0][HSUM_W-1:0] hgroup_t;
    typedef hgroup_t [N_LINES-1:0]          hlines_t;
    typedef logic [N_LINES-1:0][BANK_W-1:0] tap_sel_t;   // tap 0 is the top row
    typedef logic [GRP_PIX-1:0][PIX_W-1:0]  ogroup_t;    // byte 0 is leftmost

endpackage

`default_nettype wire

//--- rtl/pyr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pyr_ctrl
    import pyr_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_start,
    input  logic [WIDTH_W-1:0]     i_width,
    input  logic [HEIGHT_W-1:0]    i_height,
    input  border_e                i_border,
    input  logic                   i_beat_valid,
    input  logic                   i_hgrp_valid,
    input  logic                   i_out_valid,
    output logic                   o_row_ready,
    output logic                   o_busy,
    output logic                   o_frame_done,
    output border_e                o_border,
    output logic                   o_row_first,
    output logic                   o_row_last,
    output logic                   o_wr_en,
    output logic [BANK_W-1:0]      o_wr_bank,
    output logic [GRP_ADDR_W-1:0]  o_grp_addr,
    output logic                   o_ver_en,
    output tap_sel_t               o_tap_sel
);

    ctrl_state_e               state;
    border_e                   border_r;
    logic [GRP_ADDR_W-1:0]     last_grp;    // groups per row minus one
    logic [HEIGHT_W-1:0]       last_row;
    logic [HEIGHT_W-1:0]       row;
    logic [GRP_ADDR_W-1:0]     beat_cnt;
    logic [GRP_ADDR_W-1:0]     grp_cnt;
    logic [GRP_ADDR_W-1:0]     out_cnt;
    logic [BANK_W-1:0]         wr_bank;
    logic                      hgrp_done;
    logic                      out_done;
    logic                      hgrp_last;
    logic                      out_last;
    logic                      first_out;
    logic                      last_out;
    logic                      row_complete;

    // bank index modulo the number of banks
    function automatic logic [BANK_W-1:0] bank_add(input logic [BANK_W-1:0] b,
                                                   input logic [BANK_W-1:0] k);
        logic [BANK_W:0] s;
        s = {1'b0, b} + {1'b0, k};
        if (s >= N_LINES) begin
            s = s - (BANK_W+1)'(N_LINES);
        end
        return s[BANK_W-1:0];
    endfunction

    assign hgrp_last = i_hgrp_valid && (grp_cnt == last_grp);
    assign out_last  = i_out_valid && (out_cnt == last_grp);
    assign first_out = (row == HEIGHT_W'(2));
    assign last_out  = (row == last_row);   // centred on the row above
    assign row_complete = (hgrp_done || hgrp_last) && (!o_ver_en || out_done || out_last);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            border_r  <= BORDER_REPLICATE;
            last_grp  <= '0;
            last_row  <= '0;
            row       <= '0;
            beat_cnt  <= '0;
            grp_cnt   <= '0;
            out_cnt   <= '0;
            wr_bank   <= '0;
            hgrp_done <= 1'b0;
            out_done  <= 1'b0;
        end else begin
            if (i_hgrp_valid) grp_cnt <= grp_cnt + 1'b1;
            if (i_out_valid)  out_cnt <= out_cnt + 1'b1;
            if (hgrp_last)    hgrp_done <= 1'b1;
            if (out_last)     out_done <= 1'b1;

            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        border_r <= i_border;
                        last_grp <= GRP_ADDR_W'((i_width >> 3) - 1'b1);
                        last_row <= i_height - 1'b1;
                        row      <= '0;
                        wr_bank  <= '0;
                        beat_cnt <= '0;
                        state    <= ST_ROW;
                    end
                end
                ST_ROW: begin
                    if (i_beat_valid) begin
                        if (o_row_last) begin
                            beat_cnt <= '0;
                            state    <= ST_DRAIN;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                ST_DRAIN: begin
                    // row stored, and its output row sent if it had one
                    if (row_complete) begin
                        grp_cnt   <= '0;
                        out_cnt   <= '0;
                        hgrp_done <= 1'b0;
                        out_done  <= 1'b0;
                        if (last_out) begin
                            state <= ST_DONE;
                        end else begin
                            row     <= row + 1'b1;
                            wr_bank <= bank_add(wr_bank, BANK_W'(1));
                            state   <= ST_ROW;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // taps from the bank rotation, rows y-4 .. y-1 sit in wr_bank+1 .. wr_bank+4
    always_comb begin
        o_tap_sel[0] = bank_add(wr_bank, BANK_W'(1));
        o_tap_sel[1] = bank_add(wr_bank, BANK_W'(2));
        o_tap_sel[2] = bank_add(wr_bank, BANK_W'(3));
        o_tap_sel[3] = bank_add(wr_bank, BANK_W'(4));
        o_tap_sel[4] = TAP_CUR;
        if (first_out) begin
            // rows -2 and -1 above row 0
            if (border_r == BORDER_REFLECT_101) begin
                o_tap_sel[0] = TAP_CUR;
                o_tap_sel[1] = bank_add(wr_bank, BANK_W'(4));
            end else begin
                o_tap_sel[0] = bank_add(wr_bank, BANK_W'(3));
                o_tap_sel[1] = bank_add(wr_bank, BANK_W'(3));
            end
        end else if (last_out) begin
            o_tap_sel[0] = bank_add(wr_bank, BANK_W'(2));
            o_tap_sel[1] = bank_add(wr_bank, BANK_W'(3));
            o_tap_sel[2] = bank_add(wr_bank, BANK_W'(4));
            o_tap_sel[3] = TAP_CUR;
            o_tap_sel[4] = (border_r == BORDER_REFLECT_101) ? bank_add(wr_bank, BANK_W'(4))
                                                            : TAP_CUR;
        end
    end

    assign o_ver_en     = (!row[0] && (row >= HEIGHT_W'(2))) || last_out;
    assign o_row_ready  = (state == ST_ROW) && (beat_cnt == '0);
    assign o_busy       = (state != ST_IDLE);
    assign o_frame_done = (state == ST_DONE);
    assign o_border     = border_r;
    assign o_row_first  = (beat_cnt == '0);
    assign o_row_last   = (beat_cnt == last_grp);
    assign o_wr_en      = i_hgrp_valid && (state != ST_IDLE);
    assign o_wr_bank    = wr_bank;
    assign o_grp_addr   = grp_cnt;

endmodule

`default_nettype wire

//--- rtl/pyr_hor_filter.sv
`timescale 1ns/1ps
`default_nettype none

module pyr_hor_filter
    import pyr_pkg::*;
(
    input  logic               clk,
    input  logic               i_beat_valid,
    input  logic [BEAT_W-1:0]  i_beat_data,
    input  logic               i_row_first,
    input  logic               i_row_last,
    input  border_e            i_border,
    output logic               o_hgrp_valid,
    output hgroup_t            o_hgrp
);

    logic [BEAT_PIX-1:0][PIX_W-1:0]   beat_pix;
    logic [BEAT_PIX+1:0][PIX_W-1:0]   hist;      // pixels 8j-2 .. 8j+7 after beat j
    logic [BEAT_PIX+2:0][PIX_W-1:0]   win;
    logic                             flush;
    logic                             s1_valid;
    logic                             s2_valid;
    logic [GRP_PIX-1:0][PIX_W:0]      s1_a;
    logic [GRP_PIX-1:0][PIX_W:0]      s1_b;
    logic [GRP_PIX-1:0][PIX_W-1:0]    s1_c;
    logic [GRP_PIX-1:0][HSUM_W-1:0]   s2_a;
    logic [GRP_PIX-1:0][HSUM_W-1:0]   s2_b;

    assign beat_pix = i_beat_data;   // pixel 0 in the low byte

    // last window pixel comes from the next beat, or from the right border
    always_comb begin
        win[BEAT_PIX+1:0] = hist;
        if (flush) begin
            win[BEAT_PIX+2] = (i_border == BORDER_REFLECT_101) ? hist[BEAT_PIX]
                                                               : hist[BEAT_PIX+1];
        end else begin
            win[BEAT_PIX+2] = beat_pix[0];
        end
    end

    always_ff @(posedge clk) begin
        if (i_beat_valid) begin
            hist[BEAT_PIX+1:2] <= beat_pix;
            if (i_row_first) begin
                // left pad, pixels -2 and -1
                if (i_border == BORDER_REFLECT_101) begin
                    hist[0] <= beat_pix[2];
                    hist[1] <= beat_pix[1];
                end else begin
                    hist[0] <= beat_pix[0];
                    hist[1] <= beat_pix[0];
                end
            end else begin
                hist[1:0] <= hist[BEAT_PIX+1:BEAT_PIX];
            end
        end
    end

    // valid chain clears itself while no beats arrive
    always_ff @(posedge clk) begin
        flush        <= i_beat_valid && i_row_last;
        s1_valid     <= (i_beat_valid && !i_row_first) || flush;
        s2_valid     <= s1_valid;
        o_hgrp_valid <= s2_valid;
    end

    // 1 4 6 4 1 as (a+e) + 4(b+d) + 4c + 2c
    always_ff @(posedge clk) begin
        for (int i = 0; i < GRP_PIX; i++) begin
            s1_a[i]   <= {1'b0, win[2*i]} + {1'b0, win[2*i+4]};
            s1_b[i]   <= {1'b0, win[2*i+1]} + {1'b0, win[2*i+3]};
            s1_c[i]   <= win[2*i+2];
            s2_a[i]   <= {3'b000, s1_a[i]} + {1'b0, s1_b[i], 2'b00};
            s2_b[i]   <= {2'b00, s1_c[i], 2'b00} + {3'b000, s1_c[i], 1'b0};
            o_hgrp[i] <= s2_a[i] + s2_b[i];
        end
    end

endmodule

`default_nettype wire

//--- rtl/pyr_line_buf.sv
`timescale 1ns/1ps
`default_nettype none

module pyr_line_buf
    import pyr_pkg::*;
(
    input  logic                   clk,
    input  logic                   i_wr_en,
    input  logic [BANK_W-1:0]      i_wr_bank,
    input  logic [GRP_ADDR_W-1:0]  i_addr,
    input  hgroup_t                i_wr_data,
    output hlines_t                o_rd_data
);

    // one bank per stored row, all read at the same column group
    for (genvar b = 0; b < N_LINES; b++) begin : g_bank
        hgroup_t mem [MAX_WIDTH/BEAT_PIX];
        hgroup_t rd_q;

        always_ff @(posedge clk) begin
            if (i_wr_en && (i_wr_bank == BANK_W'(b))) begin
                mem[i_addr] <= i_wr_data;
            end
            rd_q <= mem[i_addr];   // old data on the bank being written
        end

        assign o_rd_data[b] = rd_q;
    end

endmodule

`default_nettype wire

//--- rtl/pyr_ver_filter.sv
`timescale 1ns/1ps
`default_nettype none

module pyr_ver_filter
    import pyr_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_hgrp_valid,
    input  hgroup_t   i_hgrp,
    input  hlines_t   i_lines,
    input  logic      i_ver_en,
    input  tap_sel_t  i_tap_sel,
    output logic      o_out_valid,
    output ogroup_t   o_out_data
);

    hgroup_t                          cur_d;      // lines up with the buffer read
    hgroup_t                          tap [N_LINES];
    logic                             v0;
    logic                             v1;
    logic                             v2;
    logic [GRP_PIX-1:0][HSUM_W:0]     s1_a;
    logic [GRP_PIX-1:0][HSUM_W:0]     s1_b;
    hgroup_t                          s1_c;
    logic [GRP_PIX-1:0][VSUM_W-1:0]   s2_a;
    logic [GRP_PIX-1:0][VSUM_W-1:0]   s2_b;
    logic [GRP_PIX-1:0][VSUM_W-1:0]   vsum;

    always_ff @(posedge clk) begin
        cur_d <= i_hgrp;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v0          <= 1'b0;
            v1          <= 1'b0;
            v2          <= 1'b0;
            o_out_valid <= 1'b0;
        end else begin
            v0          <= i_hgrp_valid && i_ver_en;
            v1          <= v0;
            v2          <= v1;
            o_out_valid <= v2;
        end
    end

    always_comb begin
        for (int k = 0; k < N_LINES; k++) begin
            if (i_tap_sel[k] == TAP_CUR) tap[k] = cur_d;
            else tap[k] = i_lines[i_tap_sel[k]];
        end
    end

    always_comb begin
        for (int i = 0; i < GRP_PIX; i++) begin
            vsum[i] = s2_a[i] + s2_b[i];
        end
    end

    // same 1 4 6 4 1 split as the row pass, rounding folded into stage 2
    always_ff @(posedge clk) begin
        for (int i = 0; i < GRP_PIX; i++) begin
            s1_a[i]       <= {1'b0, tap[0][i]} + {1'b0, tap[4][i]};
            s1_b[i]       <= {1'b0, tap[1][i]} + {1'b0, tap[3][i]};
            s1_c[i]       <= tap[2][i];
            s2_a[i]       <= {3'b000, s1_a[i]} + {1'b0, s1_b[i], 2'b00};
            s2_b[i]       <= {2'b00, s1_c[i], 2'b00} + {3'b000, s1_c[i], 1'b0} + ROUND;
            o_out_data[i] <= vsum[i][VSUM_W-1 -: PIX_W];    // divide by 256
        end
    end

endmodule

`default_nettype wire

//--- rtl/pyr_top.sv
`timescale 1ns/1ps
`default_nettype none

module pyr_top
    import pyr_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_start,
    input  logic [WIDTH_W-1:0]   i_width,
    input  logic [HEIGHT_W-1:0]  i_height,
    input  border_e              i_border,
    input  logic                 i_beat_valid,
    input  logic [BEAT_W-1:0]    i_beat_data,
    output logic                 o_row_ready,
    output logic                 o_busy,
    output logic                 o_out_valid,
    output ogroup_t              o_out_data,
    output logic                 o_frame_done
);

    border_e                 border;
    logic                    row_first;
    logic                    row_last;
    logic                    hgrp_valid;
    hgroup_t                 hgrp;
    logic                    wr_en;
    logic [BANK_W-1:0]       wr_bank;
    logic [GRP_ADDR_W-1:0]   grp_addr;
    hlines_t                 lines;
    logic                    ver_en;
    tap_sel_t                tap_sel;

    pyr_ctrl pyr_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .i_start      (i_start),
        .i_width      (i_width),
        .i_height     (i_height),
        .i_border     (i_border),
        .i_beat_valid (i_beat_valid),
        .i_hgrp_valid (hgrp_valid),
        .i_out_valid  (o_out_valid),
        .o_row_ready  (o_row_ready),
        .o_busy       (o_busy),
        .o_frame_done (o_frame_done),
        .o_border     (border),
        .o_row_first  (row_first),
        .o_row_last   (row_last),
        .o_wr_en      (wr_en),
        .o_wr_bank    (wr_bank),
        .o_grp_addr   (grp_addr),
        .o_ver_en     (ver_en),
        .o_tap_sel    (tap_sel)
    );

    pyr_hor_filter pyr_hor_filter_i (
        .clk          (clk),
        .i_beat_valid (i_beat_valid),
        .i_beat_data  (i_beat_data),
        .i_row_first  (row_first),
        .i_row_last   (row_last),
        .i_border     (border),
        .o_hgrp_valid (hgrp_valid),
        .o_hgrp       (hgrp)
    );

    pyr_line_buf pyr_line_buf_i (
        .clk       (clk),
        .i_wr_en   (wr_en),
        .i_wr_bank (wr_bank),
        .i_addr    (grp_addr),
        .i_wr_data (hgrp),
        .o_rd_data (lines)
    );

    pyr_ver_filter pyr_ver_filter_i (
        .clk          (clk),
        .rst          (rst),
        .i_hgrp_valid (hgrp_valid),
        .i_hgrp       (hgrp),
        .i_lines      (lines),
        .i_ver_en     (ver_en),
        .i_tap_sel    (tap_sel),
        .o_out_valid  (o_out_valid),
        .o_out_data   (o_out_data)
    );

endmodule

`default_nettype wire

//--- verification/pyr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pyr_tb
    import pyr_pkg::*;
();

    localparam int          CLK_PERIOD = 20;
    localparam int          RST_CYCLES = 10;
    localparam logic [31:0] SEED       = 32'h33ee_73b0;
    localparam int          IMG_W      = 48;
    localparam int          IMG_H      = 10;
    // pixels sent over the whole run including both flat frames
    localparam int          TOTAL_PIX  = 16*6 + 32*8 + 2*16*6 + 48*10 + 16*6;
    localparam int          WDOG_CYCLES = 1000 + 8*TOTAL_PIX;

    logic                  clk;
    logic                  rst;
    logic                  i_start;
    logic [WIDTH_W-1:0]    i_width;
    logic [HEIGHT_W-1:0]   i_height;
    border_e               i_border;
    logic                  i_beat_valid;
    logic [BEAT_W-1:0]     i_beat_data;
    logic                  o_row_ready;
    logic                  o_busy;
    logic                  o_out_valid;
    ogroup_t               o_out_data;
    logic                  o_frame_done;

    logic [PIX_W-1:0]      img [IMG_H][IMG_W];   // frame under test
    ogroup_t               got_q [$];            // every output group of the run
    int                    done_cnt;
    int                    errors;
    int                    checks;

    pyr_top pyr_top_i (
        .clk          (clk),
        .rst          (rst),
        .i_start      (i_start),
        .i_width      (i_width),
        .i_height     (i_height),
        .i_border     (i_border),
        .i_beat_valid (i_beat_valid),
        .i_beat_data  (i_beat_data),
        .o_row_ready  (o_row_ready),
        .o_busy       (o_busy),
        .o_out_valid  (o_out_valid),
        .o_out_data   (o_out_data),
        .o_frame_done (o_frame_done)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d clock cycles", WDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (o_out_valid === 1'b1) got_q.push_back(o_out_data);
        if (o_frame_done === 1'b1) done_cnt++;
    end

    task automatic check_group(input ogroup_t got, input ogroup_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    function automatic int kernel_tap(input int k);
        case (k)
            0, 4:    return 1;
            1, 3:    return 4;
            default: return 6;
        endcase
    endfunction

    // index outside 0..n-1 mapped back into the frame
    function automatic int border_index(input int p, input int n, input border_e border);
        if (p < 0) begin
            return (border == BORDER_REFLECT_101) ? -p : 0;
        end
        if (p >= n) begin
            return (border == BORDER_REFLECT_101) ? 2*(n-1) - p : n-1;
        end
        return p;
    endfunction

    // 5x5 binomial at the even input pixel under output (oy, ox)
    function automatic int ref_pixel(input int oy, input int ox, input int w, input int h,
                                     input border_e border);
        int acc;
        int yy;
        int xx;
        acc = 0;
        for (int dy = 0; dy < 5; dy++) begin
            yy = border_index(2*oy + dy - 2, h, border);
            for (int dx = 0; dx < 5; dx++) begin
                xx = border_index(2*ox + dx - 2, w, border);
                acc += kernel_tap(dy) * kernel_tap(dx) * int'(img[yy][xx]);
            end
        end
        return (acc + 128) / 256;
    endfunction

    task automatic make_ramp(input int w, input int h);
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) img[y][x] = PIX_W'(9*x + 20*y);
        end
    endtask

    task automatic random_image(input int w, input int h);
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) img[y][x] = PIX_W'($urandom);
        end
    endtask

    task automatic flat_image(input int w, input int h, input logic [PIX_W-1:0] v);
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) img[y][x] = v;
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int err0);
        $display("test %-26s finished with %0d errors", name, errors - err0);
    endtask

    // start a frame, stream its rows on o_row_ready, wait for the end of frame
    task automatic run_frame(input int w, input int h, input border_e border, output int base);
        int done0;
        base = got_q.size();
        done0 = done_cnt;
        check_flag(o_busy, 1'b0, "busy low before start");
        i_width  = WIDTH_W'(w);
        i_height = HEIGHT_W'(h);
        i_border = border;
        i_start  = 1'b1;
        @(negedge clk);
        i_start = 1'b0;
        check_flag(o_busy, 1'b1, "busy after start");
        check_flag(o_row_ready, 1'b1, "row ready after start");
        for (int y = 0; y < h; y++) begin
            while (!o_row_ready) @(negedge clk);
            for (int b = 0; b < w/BEAT_PIX; b++) begin
                i_beat_valid = 1'b1;
                for (int i = 0; i < BEAT_PIX; i++) begin
                    i_beat_data[PIX_W*i +: PIX_W] = img[y][BEAT_PIX*b + i];
                end
                @(negedge clk);
                check_flag(o_row_ready, 1'b0, "row ready low while a row is sent");
            end
            i_beat_valid = 1'b0;
        end
        while (!o_frame_done) @(negedge clk);
        @(negedge clk);
        check_flag(o_busy, 1'b0, "busy low after frame done");
        repeat (4) @(negedge clk);   // catch a late group or a second done pulse
        check_flag(done_cnt - done0 == 1, 1'b1,
                   $sformatf("frame %0dx%0d gave %0d frame done pulses, one expected",
                             w, h, done_cnt - done0));
        check_flag(got_q.size() - base == (h/2) * (w/BEAT_PIX), 1'b1,
                   $sformatf("frame %0dx%0d gave %0d output groups, %0d expected",
                             w, h, got_q.size() - base, (h/2) * (w/BEAT_PIX)));
    endtask

    task automatic compare_model(input int base, input int w, input int h,
                                 input border_e border, input string name);
        int      gpr;
        ogroup_t exp;
        gpr = w / BEAT_PIX;
        for (int n = 0; n < (h/2) * gpr && base + n < got_q.size(); n++) begin
            for (int i = 0; i < GRP_PIX; i++) begin
                exp[i] = PIX_W'(ref_pixel(n / gpr, GRP_PIX*(n % gpr) + i, w, h, border));
            end
            check_group(got_q[base + n], exp,
                        $sformatf("%s out row %0d group %0d", name, n / gpr, n % gpr));
        end
    endtask

    task automatic reset_flags();
        int err0;
        err0 = errors;
        apply_reset();
        check_flag(o_busy, 1'b0, "busy after reset");
        check_flag(o_out_valid, 1'b0, "out valid after reset");
        check_flag(o_row_ready, 1'b0, "row ready after reset");
        check_flag(o_frame_done, 1'b0, "frame done after reset");
        report_test("reset state", err0);
    endtask

    task automatic ramp_reflect();
        int err0;
        int base;
        err0 = errors;
        make_ramp(16, 6);
        run_frame(16, 6, BORDER_REFLECT_101, base);
        compare_model(base, 16, 6, BORDER_REFLECT_101, "ramp");
        report_test("ramp 16x6 reflect_101", err0);
    endtask

    task automatic random_replicate();
        int err0;
        int base;
        err0 = errors;
        random_image(32, 8);
        run_frame(32, 8, BORDER_REPLICATE, base);
        compare_model(base, 32, 8, BORDER_REPLICATE, "random");
        report_test("random 32x8 replicate", err0);
    endtask

    // a constant image must come back unchanged
    task automatic flat_frame(input border_e border);
        int               base;
        logic [PIX_W-1:0] v;
        ogroup_t          exp;
        v = PIX_W'($urandom);
        exp = {GRP_PIX{v}};
        flat_image(16, 6, v);
        run_frame(16, 6, border, base);
        for (int n = base; n < got_q.size(); n++) begin
            check_group(got_q[n], exp, $sformatf("flat %h group %0d", v, n - base));
        end
    endtask

    task automatic flat_images();
        int err0;
        err0 = errors;
        flat_frame(BORDER_REPLICATE);
        flat_frame(BORDER_REFLECT_101);
        report_test("flat image, both borders", err0);
    endtask

    task automatic back_to_back();
        int err0;
        int base;
        err0 = errors;
        random_image(48, 10);
        run_frame(48, 10, BORDER_REPLICATE, base);
        compare_model(base, 48, 10, BORDER_REPLICATE, "48x10");
        random_image(16, 6);
        run_frame(16, 6, BORDER_REFLECT_101, base);
        compare_model(base, 16, 6, BORDER_REFLECT_101, "16x6");
        report_test("back to back 48x10, 16x6", err0);
    endtask

    initial begin
        int seed_ret;
        errors       = 0;
        checks       = 0;
        done_cnt     = 0;
        rst          = 1'b1;
        i_start      = 1'b0;
        i_width      = '0;
        i_height     = '0;
        i_border     = BORDER_REPLICATE;
        i_beat_valid = 1'b0;
        i_beat_data  = '0;
        seed_ret     = $urandom(SEED);
        reset_flags();
        ramp_reflect();
        random_replicate();
        flat_images();
        back_to_back();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/pyr_pkg.sv
rtl/pyr_ctrl.sv
rtl/pyr_hor_filter.sv
rtl/pyr_line_buf.sv
rtl/pyr_ver_filter.sv
rtl/pyr_top.sv
verification/pyr_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and pass only when the testbench reports a pass
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module pyr_tb \
    -f vlog.f -o pyr_sim &&
./obj_dir/pyr_sim | tee /dev/stderr | grep -q "Verification passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
